//--- design/amiga_video_pkg.sv
////////////////////////////////////////
// amiga video package
// bridge register map, raster window
// constants and the scaler word layout
////////////////////////////////////////

`default_nettype none

package amiga_video_pkg;

	////////////////////////////////////////
	// bridge register map
	////////////////////////////////////////

	localparam logic [23:0] VIDEO_REG_BASE = 24'h200000; // upper address bits
	localparam logic [7:0]  X_OFFSET_ADDR  = 8'h00;
	localparam logic [7:0]  Y_OFFSET_ADDR  = 8'h04;
	localparam int          OFFSET_W       = 8;

	////////////////////////////////////////
	// raster window and indicator boxes
	////////////////////////////////////////

	localparam int                 COUNT_W   = 10;
	localparam logic [COUNT_W-1:0] BOX_Y_MIN = 10'd5; // both boxes share the rows
	localparam logic [COUNT_W-1:0] BOX_Y_MAX = 10'd15;
	localparam logic [COUNT_W-1:0] FDD_X_MIN = 10'd5;
	localparam logic [COUNT_W-1:0] FDD_X_MAX = 10'd15;
	localparam logic [COUNT_W-1:0] HDD_X_MIN = 10'd20;
	localparam logic [COUNT_W-1:0] HDD_X_MAX = 10'd35;
	localparam logic [7:0]         INDICATOR_LEVEL = 8'hF0;

	localparam int HS_DELAY = 4; // stages from hs detect to video_hs

	// scaler word, pixel view
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} video_pixel_t;

	// scaler word, control view sent outside de
	typedef struct packed {
		logic [7:0]  pad_hi;
		logic [2:0]  res;     // resolution slot
		logic [9:0]  pad_mid;
		logic        field;
		logic        lace;
		logic        pad_lo;
	} video_ctrl_t;

	typedef union packed {
		video_pixel_t pix;
		video_ctrl_t  ctrl;
	} video_word_u;

endpackage

`default_nettype wire

//--- design/video_raster_if.sv
////////////////////////////////////////
// raster bundle
// position and sync events from the
// tracker to the pixel composer
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

interface video_raster_if;
	import amiga_video_pkg::*;

	logic               active;      // no blank asserted
	logic               vs_fall;     // one cycle pulse
	logic               hblank_rise; // one cycle pulse
	logic [COUNT_W-1:0] x_pos;       // de pixels already out on this line
	logic [COUNT_W-1:0] y_pos;       // de lines started this frame

	modport tracker (
		output active,
		output vs_fall,
		output hblank_rise,
		output x_pos,
		output y_pos
	);

	modport composer (
		input active,
		input vs_fall,
		input hblank_rise,
		input x_pos,
		input y_pos
	);

endinterface

`default_nettype wire

//--- design/bridge_regs.sv
////////////////////////////////////////
// bridge registers
// picture offsets written and read back
// over the bridge bus, other reads zero
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module bridge_regs (
	input  wire                                   clk_74a,
	input  wire                                   cpu_rst,
	input  wire  [31:0]                           bridge_addr,
	input  wire                                   bridge_rd,
	input  wire                                   bridge_wr,
	input  wire  [31:0]                           bridge_wr_data,
	output logic [31:0]                           bridge_rd_data,
	output logic [amiga_video_pkg::OFFSET_W-1:0]  x_offset,
	output logic [amiga_video_pkg::OFFSET_W-1:0]  y_offset
);
	import amiga_video_pkg::*;

	logic        in_region;
	logic [31:0] rd_sel;
	logic [31:0] rd_stage; // first read stage, holds between reads

	assign in_region = (bridge_addr[31:8] == VIDEO_REG_BASE);

	////////////////////////////////////////
	// offset writes
	////////////////////////////////////////

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			x_offset <= '0;
			y_offset <= '0;
		end else if (bridge_wr && in_region) begin
			case (bridge_addr[7:0])
				X_OFFSET_ADDR: x_offset <= bridge_wr_data[OFFSET_W-1:0];
				Y_OFFSET_ADDR: y_offset <= bridge_wr_data[OFFSET_W-1:0];
				default: ; // unused slot in the region
			endcase
		end
	end

	////////////////////////////////////////
	// read decode
	////////////////////////////////////////

	// anything not decoded below reads as zero
	always_comb begin
		rd_sel = '0;
		if (in_region) begin
			case (bridge_addr[7:0])
				X_OFFSET_ADDR: rd_sel = {{(32-OFFSET_W){1'b0}}, x_offset};
				Y_OFFSET_ADDR: rd_sel = {{(32-OFFSET_W){1'b0}}, y_offset};
				default:       rd_sel = '0;
			endcase
		end
	end

	// two stages, data shows two cycles after bridge_rd
	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			rd_stage       <= '0;
			bridge_rd_data <= '0;
		end else begin
			if (bridge_rd) begin
				rd_stage <= rd_sel; // address sampled with the strobe
			end
			bridge_rd_data <= rd_stage;
		end
	end

endmodule

`default_nettype wire

//--- design/raster_tracker.sv
////////////////////////////////////////
// raster tracker
// finds sync and blank edges, skips the
// offset region and drives de and syncs
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module raster_tracker (
	input  wire                                  clk_74a,
	input  wire                                  cpu_rst,
	input  wire                                  hs,
	input  wire                                  vs,
	input  wire                                  hblank,
	input  wire                                  vblank,
	input  wire [amiga_video_pkg::OFFSET_W-1:0]  x_offset,
	input  wire [amiga_video_pkg::OFFSET_W-1:0]  y_offset,
	video_raster_if.tracker                      raster,
	output logic                                 video_de,
	output logic                                 video_hs,
	output logic                                 video_vs
);
	import amiga_video_pkg::*;

	logic                hs_reg;
	logic                vs_reg;
	logic                hblank_reg;
	logic                hs_fall;
	logic                vs_fall;
	logic                active;
	logic [HS_DELAY-1:0] hs_chain;   // hs detect shifted toward video_hs
	logic [OFFSET_W-1:0] x_skip;     // pixels still hidden on this line
	logic [OFFSET_W-1:0] y_skip;     // lines still hidden in this frame
	logic [COUNT_W-1:0]  x_pos;
	logic [COUNT_W-1:0]  y_pos;
	logic                de_reg;

	assign hs_fall = hs_reg & ~hs;
	assign vs_fall = vs_reg & ~vs;
	assign active  = ~hblank & ~vblank;

	assign raster.active      = active;
	assign raster.vs_fall     = vs_fall;
	assign raster.hblank_rise = hblank & ~hblank_reg;
	assign raster.x_pos       = x_pos;
	assign raster.y_pos       = y_pos;

	////////////////////////////////////////
	// edge history
	////////////////////////////////////////

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			hs_reg     <= 1'b0;
			vs_reg     <= 1'b0;
			hblank_reg <= 1'b0;
		end else begin
			hs_reg     <= hs;
			vs_reg     <= vs;
			hblank_reg <= hblank;
		end
	end

	// scaler wants hs a few clocks late
	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			hs_chain <= '0;
			video_hs <= 1'b0;
		end else begin
			hs_chain <= {hs_chain[HS_DELAY-2:0], hs_fall};
			video_hs <= hs_chain[HS_DELAY-1];
		end
	end

	////////////////////////////////////////
	// offset countdown and de
	////////////////////////////////////////

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			video_de <= 1'b0;
			video_vs <= 1'b0;
			x_skip   <= '0;
			y_skip   <= '0;
			x_pos    <= '0;
			y_pos    <= '0;
			de_reg   <= 1'b0;
		end else begin
			video_de <= 1'b0;
			video_vs <= 1'b0;
			de_reg   <= video_de;

			if (video_de) begin
				x_pos <= x_pos + 1'b1;
			end
			if (video_de && !de_reg) begin
				y_pos <= y_pos + 1'b1; // new de line
			end

			// start of line
			if (hs_fall) begin
				x_skip <= x_offset;
				x_pos  <= '0;
				if (y_skip != '0) begin
					y_skip <= y_skip - 1'b1;
				end
			end

			// start of frame wins over the active window
			if (vs_fall) begin
				y_skip   <= y_offset;
				y_pos    <= '0;
				video_vs <= 1'b1;
			end else if (active) begin
				if (x_skip == '0 && y_skip == '0) begin
					video_de <= 1'b1;
				end
				if (x_skip != '0) begin
					x_skip <= x_skip - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/pixel_composer.sv
////////////////////////////////////////
// pixel composer
// builds the scaler word: pixels, drive
// boxes, interlace and resolution codes
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module pixel_composer (
	input  wire              clk_74a,
	input  wire              cpu_rst,
	video_raster_if.composer raster,
	input  wire  [7:0]       red,
	input  wire  [7:0]       green,
	input  wire  [7:0]       blue,
	input  wire              lace,
	input  wire              field1,
	input  wire  [1:0]       res,
	input  wire              fdd_led,
	input  wire              hdd_led,
	output logic [23:0]      video_rgb
);
	import amiga_video_pkg::*;

	logic [1:0]  res_code;   // taken at each vs
	logic        in_rows;
	logic        in_fdd_box;
	logic        in_hdd_box;
	video_word_u word_next;

	// box hit tests on the de position
	assign in_rows    = (raster.y_pos >= BOX_Y_MIN) && (raster.y_pos <= BOX_Y_MAX);
	assign in_fdd_box = in_rows && (raster.x_pos >= FDD_X_MIN) && (raster.x_pos <= FDD_X_MAX);
	assign in_hdd_box = in_rows && (raster.x_pos >= HDD_X_MIN) && (raster.x_pos <= HDD_X_MAX);

	////////////////////////////////////////
	// word select
	////////////////////////////////////////

	always_comb begin
		word_next = '0;
		if (raster.vs_fall) begin
			word_next.ctrl.field = field1 & lace;
			word_next.ctrl.lace  = lace;
		end else if (raster.active) begin
			if (fdd_led && in_fdd_box) begin
				word_next.pix.green = INDICATOR_LEVEL; // floppy box
			end else if (hdd_led && in_hdd_box) begin
				word_next.pix.red = INDICATOR_LEVEL;   // disk box
			end else begin
				word_next.pix.red   = red;
				word_next.pix.green = green;
				word_next.pix.blue  = blue;
			end
		end else if (raster.hblank_rise) begin
			// code zero gives an all zero word
			word_next.ctrl.res = {1'b0, res_code};
		end
	end

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			res_code  <= '0;
			video_rgb <= '0;
		end else begin
			if (raster.vs_fall) begin
				res_code <= {res[1], res[0] & lace}; // low bit only in lace
			end
			video_rgb <= word_next;
		end
	end

endmodule

`default_nettype wire

//--- design/core_video_top.sv
////////////////////////////////////////
// core video top
// bridge offset registers and the video
// path to the scaler
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module core_video_top (
	input  wire         clk_74a,
	input  wire         cpu_rst,

	// bridge bus
	input  wire  [31:0] bridge_addr,
	input  wire         bridge_rd,
	input  wire         bridge_wr,
	input  wire  [31:0] bridge_wr_data,
	output logic [31:0] bridge_rd_data,

	// raw amiga video
	input  wire         hs,
	input  wire         vs,
	input  wire         hblank,
	input  wire         vblank,
	input  wire  [7:0]  red,
	input  wire  [7:0]  green,
	input  wire  [7:0]  blue,
	input  wire         lace,
	input  wire         field1,
	input  wire  [1:0]  res,
	input  wire         fdd_led,
	input  wire         hdd_led,

	// scaler side
	output logic [23:0] video_rgb,
	output logic        video_de,
	output logic        video_hs,
	output logic        video_vs
);
	import amiga_video_pkg::*;

	logic [OFFSET_W-1:0] x_offset;
	logic [OFFSET_W-1:0] y_offset;

	video_raster_if raster_bus ();

	bridge_regs i_bridge_regs (
		.clk_74a        (clk_74a),
		.cpu_rst        (cpu_rst),
		.bridge_addr    (bridge_addr),
		.bridge_rd      (bridge_rd),
		.bridge_wr      (bridge_wr),
		.bridge_wr_data (bridge_wr_data),
		.bridge_rd_data (bridge_rd_data),
		.x_offset       (x_offset),
		.y_offset       (y_offset)
	);

	raster_tracker i_raster_tracker (
		.clk_74a  (clk_74a),
		.cpu_rst  (cpu_rst),
		.hs       (hs),
		.vs       (vs),
		.hblank   (hblank),
		.vblank   (vblank),
		.x_offset (x_offset),
		.y_offset (y_offset),
		.raster   (raster_bus.tracker),
		.video_de (video_de),
		.video_hs (video_hs),
		.video_vs (video_vs)
	);

	pixel_composer i_pixel_composer (
		.clk_74a   (clk_74a),
		.cpu_rst   (cpu_rst),
		.raster    (raster_bus.composer),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.lace      (lace),
		.field1    (field1),
		.res       (res),
		.fdd_led   (fdd_led),
		.hdd_led   (hdd_led),
		.video_rgb (video_rgb)
	);

endmodule

`default_nettype wire

//--- sim/tb_core_video.sv
////////////////////////////////////////
// core video testbench
// raster and bridge stimulus, checked
// against a model of the video rules
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module tb_core_video;
	import amiga_video_pkg::*;

	localparam int LINE_LEN    = 64;
	localparam int HS_LEN      = 4;  // hs low at line start
	localparam int HB_LEN      = 12;
	localparam int VS_COL      = 6;  // vs falls inside the blank of line 0
	localparam int VB_LINES    = 3;
	localparam int FRAME_LINES = 24;
	localparam int SYNC_WAIT   = 20;

	logic        clk_74a;
	logic        cpu_rst;
	logic [31:0] bridge_addr;
	logic        bridge_rd;
	logic        bridge_wr;
	logic [31:0] bridge_wr_data;
	logic [31:0] bridge_rd_data;
	logic        hs;
	logic        vs;
	logic        hblank;
	logic        vblank;
	logic [7:0]  red;
	logic [7:0]  green;
	logic [7:0]  blue;
	logic        lace;
	logic        field1;
	logic [1:0]  res;
	logic        fdd_led;
	logic        hdd_led;
	logic [23:0] video_rgb;
	logic        video_de;
	logic        video_hs;
	logic        video_vs;

	integer seed;

	logic [31:0] last_read = '0; // data of the previous bridge read

	// model state
	int                  x_cfg = 0;
	int                  y_cfg = 0;
	int                  act_cnt;   // active cycles since hs fall
	int                  hs_cnt;    // hs falls since vs fall
	int                  xp;
	int                  yp;
	int                  hs_falls = 0;
	int                  vs_falls = 0;
	int                  hs_pulses = 0;
	int                  vs_pulses = 0;
	logic                hs_p;
	logic                vs_p;
	logic                hb_p;
	logic                de_last;
	logic [HS_DELAY-1:0] hf_hist;
	logic [1:0]          res_code;
	logic                exp_de;
	logic                exp_hs;
	logic                exp_vs;
	video_word_u         exp_rgb;
	logic                model_valid = 1'b0;
	logic                in_reset;

	core_video_top i_dut (.*);

	initial begin
		clk_74a = 1'b0;
		forever #5 clk_74a = ~clk_74a;
	end

	task automatic stop_on_failure();
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Fail at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
			stop_on_failure();
		end
	endtask

	////////////////////////////////////////
	// reference model of the video path
	////////////////////////////////////////

	// sees the inputs the DUT samples at this same edge
	always @(posedge clk_74a) begin : model
		logic hf;
		logic vf;
		logic hbr;
		logic act;
		logic de_now;
		logic in_rows;
		de_now      = exp_de;
		hf          = hs_p & ~hs;
		vf          = vs_p & ~vs;
		hbr         = hblank & ~hb_p;
		act         = ~hblank & ~vblank;
		model_valid = 1'b1;
		in_reset    = ~cpu_rst;
		if (!cpu_rst) begin
			{hs_p, vs_p, hb_p, de_last, exp_de, exp_hs, exp_vs} = '0;
			hf_hist  = '0;
			res_code = '0;
			exp_rgb  = '0;
			xp       = 0;
			yp       = 0;
			act_cnt  = 1000; // nothing hidden until the first sync
			hs_cnt   = 1000;
		end else begin
			exp_de  = act && !vf && hs_cnt >= y_cfg && act_cnt >= x_cfg;
			exp_hs  = hf_hist[HS_DELAY-1];
			hf_hist = {hf_hist[HS_DELAY-2:0], hf};
			exp_vs  = vf;
			in_rows = yp >= BOX_Y_MIN && yp <= BOX_Y_MAX;
			exp_rgb = '0;
			if (vf) begin
				exp_rgb.ctrl.field = field1 & lace;
				exp_rgb.ctrl.lace  = lace;
			end else if (act) begin
				if (fdd_led && in_rows && xp >= FDD_X_MIN && xp <= FDD_X_MAX)
					exp_rgb.pix.green = INDICATOR_LEVEL;
				else if (hdd_led && in_rows && xp >= HDD_X_MIN && xp <= HDD_X_MAX)
					exp_rgb.pix.red = INDICATOR_LEVEL;
				else
					exp_rgb.pix = {red, green, blue};
			end else if (hbr) begin
				exp_rgb.ctrl.res = {1'b0, res_code};
			end
			if (vf) res_code = {res[1], res[0] & lace};
			if (act && !vf) act_cnt = act_cnt + 1;
			if (hf) begin
				act_cnt = 0;
				hs_cnt  = hs_cnt + 1;
			end
			if (vf) hs_cnt = 0;
			xp       = hf ? 0 : xp + de_now;  // de pixels before the next cycle
			yp       = vf ? 0 : yp + (de_now && !de_last);
			de_last  = de_now;
			hs_p     = hs;
			vs_p     = vs;
			hb_p     = hblank;
			hs_falls = hs_falls + hf;
			vs_falls = vs_falls + vf;
		end
	end

	// outputs are stable away from the rising edge
	always @(negedge clk_74a) begin
		if (model_valid) begin
			check_equal("video_de", exp_de, video_de);
			check_equal("video_hs", exp_hs, video_hs);
			check_equal("video_vs", exp_vs, video_vs);
			check_equal("video_rgb", exp_rgb, video_rgb);
			if (in_reset) check_equal("bridge_rd_data", 32'd0, bridge_rd_data);
			hs_pulses = hs_pulses + video_hs;
			vs_pulses = vs_pulses + video_vs;
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic write_register(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk_74a);
		bridge_addr    <= addr;
		bridge_wr_data <= data;
		bridge_wr      <= 1'b1;
		@(posedge clk_74a);
		bridge_wr      <= 1'b0;
	endtask

	task automatic read_and_compare(input logic [31:0] addr, input logic [31:0] expected);
		@(posedge clk_74a);
		bridge_addr <= addr;
		bridge_rd   <= 1'b1;
		@(posedge clk_74a);
		bridge_rd   <= 1'b0;
		@(negedge clk_74a); // first cycle after the strobe, old data
		check_equal("bridge_rd_data", last_read, bridge_rd_data);
		@(posedge clk_74a);
		@(negedge clk_74a); // second cycle after the strobe
		check_equal("bridge_rd_data", expected, bridge_rd_data);
		@(negedge clk_74a);
		check_equal("bridge_rd_data", expected, bridge_rd_data); // still held
		last_read = expected;
	endtask

	task automatic drive_frame(input int frame);
		for (int line = 0; line < FRAME_LINES; line++) begin
			for (int col = 0; col < LINE_LEN; col++) begin
				@(posedge clk_74a);
				hs     <= col >= HS_LEN;
				vs     <= !((line == 0 && col >= VS_COL) || line == 1);
				hblank <= col < HB_LEN;
				vblank <= line < VB_LINES;
				red    <= $random(seed);
				green  <= $random(seed);
				blue   <= $random(seed);
				if (line == 0 && col == 0) begin
					field1  <= frame[0];
					lace    <= frame[1];
					res     <= $random(seed);
					fdd_led <= (frame % 3) != 1;
					hdd_led <= (frame % 3) != 2;
				end
			end
		end
		@(posedge clk_74a);
		{hs, vs, hblank, vblank} <= 4'hF; // raster idle
	endtask

	task automatic wait_for_sync_pulses();
		int waited;
		waited = 0;
		while ((hs_pulses != hs_falls || vs_pulses != vs_falls) && waited < SYNC_WAIT) begin
			@(posedge clk_74a);
			waited++;
		end
		if (hs_pulses != hs_falls || vs_pulses != vs_falls) begin
			$display("Timeout: %0d hs and %0d vs falls gave %0d hs and %0d vs pulses",
				hs_falls, vs_falls, hs_pulses, vs_pulses);
			stop_on_failure();
		end
	endtask

	initial begin
		seed           = 89;
		cpu_rst        = 1'b0;
		bridge_addr    = '0;
		bridge_rd      = 1'b0;
		bridge_wr      = 1'b0;
		bridge_wr_data = '0;
		{hs, vs, hblank, vblank} = 4'hF;
		{red, green, blue} = '0;
		lace    = 1'b0;
		field1  = 1'b0;
		res     = '0;
		fdd_led = 1'b0;
		hdd_led = 1'b0;
		repeat (4) @(posedge clk_74a);
		cpu_rst <= 1'b1;

		// offsets over the bridge
		write_register({VIDEO_REG_BASE, X_OFFSET_ADDR}, 32'hA5C3_7E03);
		x_cfg = 3;
		write_register({VIDEO_REG_BASE, Y_OFFSET_ADDR}, 32'h1234_5604);
		y_cfg = 4;
		write_register(32'h3000_0000, 32'h0000_00FF); // outside the region
		write_register({VIDEO_REG_BASE, 8'h0C}, 32'h0000_00EE);
		read_and_compare({VIDEO_REG_BASE, X_OFFSET_ADDR}, 32'h0000_0003);
		read_and_compare({VIDEO_REG_BASE, Y_OFFSET_ADDR}, 32'h0000_0004);
		read_and_compare({VIDEO_REG_BASE, 8'h08}, 32'h0);
		read_and_compare(32'h1000_0000, 32'h0);

		for (int f = 0; f < 4; f++) drive_frame(f);
		wait_for_sync_pulses();

		write_register({VIDEO_REG_BASE, X_OFFSET_ADDR}, 32'h0000_0007);
		x_cfg = 7;
		write_register({VIDEO_REG_BASE, Y_OFFSET_ADDR}, 32'h0000_0000);
		y_cfg = 0;
		read_and_compare({VIDEO_REG_BASE, X_OFFSET_ADDR}, 32'h0000_0007);
		for (int f = 4; f < 6; f++) drive_frame(f);
		wait_for_sync_pulses();

		if (vs_pulses == 6 && hs_pulses == 6 * FRAME_LINES) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("Fail at %0t: sync pulses expected %0d vs and %0d hs, got %0d and %0d",
				$time, 6, 6 * FRAME_LINES, vs_pulses, hs_pulses);
			stop_on_failure();
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
design/amiga_video_pkg.sv
design/video_raster_if.sv
design/bridge_regs.sv
design/raster_tracker.sv
design/pixel_composer.sv
design/core_video_top.sv
sim/tb_core_video.sv

//--- Bender.yml
package:
  name: core_video

sources:
  # package and interface first
  - design/amiga_video_pkg.sv
  - design/video_raster_if.sv

  # video path and bridge registers
  - design/bridge_regs.sv
  - design/raster_tracker.sv
  - design/pixel_composer.sv
  - design/core_video_top.sv

  # testbench
  - target: simulation
    files:
      - sim/tb_core_video.sv
